//--- verilog/qoi_settings.svh
// QOI encoder constants shared by the RTL and the testbench model
// Tags, biases and limits follow the QOI format; no file header is produced
`ifndef QOI_SETTINGS_SVH
`define QOI_SETTINGS_SVH

`define QOI_TABLE_SIZE 64
`define QOI_MAX_RUN 62
`define QOI_START_PIXEL 32'h000000FF

// Colour hash weights for r, g, b, a
`define QOI_HASH_R 3
`define QOI_HASH_G 5
`define QOI_HASH_B 7
`define QOI_HASH_A 11

`define QOI_DIFF_BIAS 2
`define QOI_LUMA_G_BIAS 32
`define QOI_LUMA_RB_BIAS 8

`define QOI_TAG_INDEX 2'b00
`define QOI_TAG_DIFF 2'b01
`define QOI_TAG_LUMA 2'b10
`define QOI_TAG_RUN 2'b11
`define QOI_TAG_RGB 8'hFE
`define QOI_TAG_RGBA 8'hFF

// Seven zero bytes then 01
`define QOI_END_BYTES 8

`endif

//--- verilog/qoiPkg.sv
// Types for the QOI encoder
// Pixel words are RGBA with red in the top byte

package qoiPkg;

	// One pixel word, compared whole or split into channels
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [7:0] r;
			logic [7:0] g;
			logic [7:0] b;
			logic [7:0] a;
		} ch;
	} qoiPixel;

	typedef enum logic [2:0] {
		opIndex,
		opDiff,
		opLuma,
		opRgb,
		opRgba
	} qoiOp;

	typedef enum logic [2:0] {
		stIdle,
		stClassify,
		stRunFlush,
		stChunk,
		stEnd,
		stDone
	} qoiState;

	// Where the output byte comes from
	typedef enum logic [1:0] {
		srcChunk,
		srcRun,
		srcEnd
	} qoiSource;

	typedef logic [5:0] qoiIndex;

endpackage

//--- verilog/qoiStageIf.sv
// Pixel state and classification shared by history, formatter and controller
// All fields are stable from the classify cycle until the pixel commits
`timescale 1ns/1ns

interface qoiStageIf;
	qoiPkg::qoiPixel curPixel;
	qoiPkg::qoiPixel prevPixel;
	qoiPkg::qoiIndex hashIndex;
	logic indexHit;
	logic samePixel;
	qoiPkg::qoiOp op;
	// 1 to 5 bytes
	logic [2:0] chunkLength;
	// Byte within a chunk or the end marker
	logic [2:0] step;

	modport history (
		output curPixel, prevPixel, hashIndex, indexHit, samePixel
	);

	modport formatter (
		input curPixel, prevPixel, hashIndex, indexHit, step,
		output op, chunkLength
	);

	modport control (
		input samePixel, chunkLength,
		output step
	);
endinterface

//--- verilog/runCounter.sv
// Run length of pixels equal to the previous one
// runFull looks ahead: high when this increment reaches the run limit
`timescale 1ns/1ns
`include "qoi_settings.svh"

module runCounter (
	input logic clk,
	input logic reset,
	input logic runInc,
	input logic runClear,
	output logic [5:0] runCount,
	output logic runFull
);
	logic atLimit;

	// One short of the limit, so the next repeat fills the run
	assign atLimit = (runCount == 6'(`QOI_MAX_RUN - 1));
	assign runFull = runInc && atLimit;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			runCount <= 6'd0;
		end else if (runClear) begin
			runCount <= 6'd0;
		end else if (runInc) begin
			runCount <= runCount + 6'd1;
		end
	end
endmodule

//--- verilog/pixelHistory.sv
// Current and previous pixel plus the 64-entry table of seen colours
// Table is cleared by reset, so each image must start from reset
// Hash, hit and same flags are combinational from the registers
`timescale 1ns/1ns
`include "qoi_settings.svh"

module pixelHistory (
	input logic clk,
	input logic reset,
	input logic [31:0] pixelData,
	input logic loadPixel,
	input logic commitPixel,
	qoiStageIf.history stage
);
	logic [31:0] seenTable [`QOI_TABLE_SIZE];
	logic [13:0] hashSum;
	logic tableWrite;

	always_ff @(posedge clk) begin
		if (loadPixel) begin
			stage.curPixel <= pixelData;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			stage.prevPixel <= `QOI_START_PIXEL;
		end else if (commitPixel) begin
			stage.prevPixel <= stage.curPixel;
		end
	end

	// Weighted sum, low six bits give the index
	assign hashSum = 14'(stage.curPixel.ch.r) * 14'(`QOI_HASH_R)
		+ 14'(stage.curPixel.ch.g) * 14'(`QOI_HASH_G)
		+ 14'(stage.curPixel.ch.b) * 14'(`QOI_HASH_B)
		+ 14'(stage.curPixel.ch.a) * 14'(`QOI_HASH_A);
	assign stage.hashIndex = hashSum[5:0];

	assign stage.indexHit = (seenTable[stage.hashIndex] == stage.curPixel.word);
	assign stage.samePixel = (stage.curPixel.word == stage.prevPixel.word);

	// Run pixels never touch the table
	assign tableWrite = commitPixel && !stage.indexHit && !stage.samePixel;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `QOI_TABLE_SIZE; i++) begin
				seenTable[i] <= 32'h0;
			end
		end else if (tableWrite) begin
			seenTable[stage.hashIndex] <= stage.curPixel.word;
		end
	end
endmodule

//--- verilog/chunkFormatter.sv
// Picks the QOI op for the current pixel and forms the byte for each step
// Op order: INDEX, RGBA on alpha change, DIFF, LUMA, RGB
// Purely combinational; the top registers the output
`timescale 1ns/1ns
`include "qoi_settings.svh"

module chunkFormatter (
	qoiStageIf.formatter stage,
	input logic [5:0] runCount,
	input qoiPkg::qoiSource byteSource,
	output logic [7:0] byteOut
);
	logic signed [8:0] dr, dg, db;
	logic signed [9:0] drg, dbg;
	logic [1:0] drBias, dgBias, dbBias;
	logic [5:0] dgLuma;
	logic [3:0] drgLuma, dbgLuma;
	logic isDiff, isLuma;
	logic [7:0] chunkByte;

	// Channel differences without wrap
	assign dr = $signed({1'b0, stage.curPixel.ch.r}) - $signed({1'b0, stage.prevPixel.ch.r});
	assign dg = $signed({1'b0, stage.curPixel.ch.g}) - $signed({1'b0, stage.prevPixel.ch.g});
	assign db = $signed({1'b0, stage.curPixel.ch.b}) - $signed({1'b0, stage.prevPixel.ch.b});
	assign drg = dr - dg;
	assign dbg = db - dg;

	assign isDiff = dr >= -(`QOI_DIFF_BIAS) && dr < `QOI_DIFF_BIAS
		&& dg >= -(`QOI_DIFF_BIAS) && dg < `QOI_DIFF_BIAS
		&& db >= -(`QOI_DIFF_BIAS) && db < `QOI_DIFF_BIAS;
	assign isLuma = dg >= -(`QOI_LUMA_G_BIAS) && dg < `QOI_LUMA_G_BIAS
		&& drg >= -(`QOI_LUMA_RB_BIAS) && drg < `QOI_LUMA_RB_BIAS
		&& dbg >= -(`QOI_LUMA_RB_BIAS) && dbg < `QOI_LUMA_RB_BIAS;

	assign drBias = 2'(dr + `QOI_DIFF_BIAS);
	assign dgBias = 2'(dg + `QOI_DIFF_BIAS);
	assign dbBias = 2'(db + `QOI_DIFF_BIAS);
	assign dgLuma = 6'(dg + `QOI_LUMA_G_BIAS);
	assign drgLuma = 4'(drg + `QOI_LUMA_RB_BIAS);
	assign dbgLuma = 4'(dbg + `QOI_LUMA_RB_BIAS);

	always_comb begin
		if (stage.indexHit) begin
			stage.op = qoiPkg::opIndex;
		end else if (stage.curPixel.ch.a != stage.prevPixel.ch.a) begin
			stage.op = qoiPkg::opRgba;
		end else if (isDiff) begin
			stage.op = qoiPkg::opDiff;
		end else if (isLuma) begin
			stage.op = qoiPkg::opLuma;
		end else begin
			stage.op = qoiPkg::opRgb;
		end
	end

	always_comb begin
		case (stage.op)
			qoiPkg::opLuma: stage.chunkLength = 3'd2;
			qoiPkg::opRgb: stage.chunkLength = 3'd4;
			qoiPkg::opRgba: stage.chunkLength = 3'd5;
			default: stage.chunkLength = 3'd1;
		endcase
	end

	always_comb begin
		case (stage.op)
			qoiPkg::opIndex: chunkByte = {`QOI_TAG_INDEX, stage.hashIndex};
			qoiPkg::opDiff: chunkByte = {`QOI_TAG_DIFF, drBias, dgBias, dbBias};
			qoiPkg::opLuma: begin
				if (stage.step == 3'd0) begin
					chunkByte = {`QOI_TAG_LUMA, dgLuma};
				end else begin
					chunkByte = {drgLuma, dbgLuma};
				end
			end
			default: begin
				// RGB and RGBA share the tag then channel layout
				case (stage.step)
					3'd0: chunkByte = (stage.op == qoiPkg::opRgba) ? `QOI_TAG_RGBA : `QOI_TAG_RGB;
					3'd1: chunkByte = stage.curPixel.ch.r;
					3'd2: chunkByte = stage.curPixel.ch.g;
					3'd3: chunkByte = stage.curPixel.ch.b;
					default: chunkByte = stage.curPixel.ch.a;
				endcase
			end
		endcase
	end

	always_comb begin
		case (byteSource)
			qoiPkg::srcRun: byteOut = {`QOI_TAG_RUN, runCount - 6'd1};
			qoiPkg::srcEnd: begin
				byteOut = (stage.step == 3'(`QOI_END_BYTES - 1)) ? 8'h01 : 8'h00;
			end
			default: byteOut = chunkByte;
		endcase
	end
endmodule

//--- verilog/qoiControl.sv
// Sequencer for one pixel at a time; no output back-pressure
// A run pixel that neither fills the run nor is last emits nothing
// done holds until reset once the end marker has gone out
`timescale 1ns/1ns
`include "qoi_settings.svh"

module qoiControl (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input logic lastPixel,
	input logic runFull,
	input logic [5:0] runCount,
	qoiStageIf.control stage,
	output logic loadPixel,
	output logic commitPixel,
	output logic runInc,
	output logic runClear,
	output qoiPkg::qoiSource byteSource,
	output logic emit,
	output logic busy,
	output logic done
);
	qoiPkg::qoiState state, nextState;
	logic [2:0] nextStep;
	logic lastFlag;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= qoiPkg::stIdle;
			stage.step <= 3'd0;
			lastFlag <= 1'b0;
		end else begin
			state <= nextState;
			stage.step <= nextStep;
			if (loadPixel) begin
				lastFlag <= lastPixel;
			end
		end
	end

	always_comb begin
		nextState = state;
		nextStep = stage.step;
		loadPixel = 1'b0;
		commitPixel = 1'b0;
		runInc = 1'b0;
		runClear = 1'b0;
		byteSource = qoiPkg::srcChunk;
		emit = 1'b0;
		case (state)
			qoiPkg::stIdle: begin
				if (pixelValid) begin
					loadPixel = 1'b1;
					nextState = qoiPkg::stClassify;
				end
			end
			qoiPkg::stClassify: begin
				nextStep = 3'd0;
				if (stage.samePixel) begin
					runInc = 1'b1;
					commitPixel = 1'b1;
					if (runFull || lastFlag) begin
						nextState = qoiPkg::stRunFlush;
					end else begin
						nextState = qoiPkg::stIdle;
					end
				end else if (runCount != 6'd0) begin
					// Pending run goes out before this pixel's chunk
					nextState = qoiPkg::stRunFlush;
				end else begin
					nextState = qoiPkg::stChunk;
				end
			end
			qoiPkg::stRunFlush: begin
				byteSource = qoiPkg::srcRun;
				emit = 1'b1;
				runClear = 1'b1;
				// Still same after commit only when the pixel itself was a run pixel
				if (!stage.samePixel) begin
					nextState = qoiPkg::stChunk;
				end else if (lastFlag) begin
					nextState = qoiPkg::stEnd;
				end else begin
					nextState = qoiPkg::stIdle;
				end
			end
			qoiPkg::stChunk: begin
				emit = 1'b1;
				if (stage.step == stage.chunkLength - 3'd1) begin
					commitPixel = 1'b1;
					nextStep = 3'd0;
					nextState = lastFlag ? qoiPkg::stEnd : qoiPkg::stIdle;
				end else begin
					nextStep = stage.step + 3'd1;
				end
			end
			qoiPkg::stEnd: begin
				byteSource = qoiPkg::srcEnd;
				emit = 1'b1;
				if (stage.step == 3'(`QOI_END_BYTES - 1)) begin
					nextStep = 3'd0;
					nextState = qoiPkg::stDone;
				end else begin
					nextStep = stage.step + 3'd1;
				end
			end
			qoiPkg::stDone: begin
				nextState = qoiPkg::stDone;
			end
			default: begin
				nextState = qoiPkg::stIdle;
			end
		endcase
	end

	assign busy = (state != qoiPkg::stIdle);
	assign done = (state == qoiPkg::stDone);
endmodule

//--- verilog/qoiEncoder.sv
// Streaming QOI encoder core, one pixel in flight at a time
// Offer a pixel only while busy is low; every byteValid byte must be taken
// Reset between images; the QOI file header is not produced
`timescale 1ns/1ns

module qoiEncoder (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input logic [31:0] pixelData,
	input logic lastPixel,
	output logic busy,
	output logic byteValid,
	output logic [7:0] byteData,
	output logic done
);
	logic loadPixel, commitPixel;
	logic runInc, runClear, runFull;
	logic [5:0] runCount;
	logic emit;
	logic [7:0] byteOut;
	qoiPkg::qoiSource byteSource;

	qoiStageIf stage();

	qoiControl control (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.lastPixel(lastPixel),
		.runFull(runFull),
		.runCount(runCount),
		.stage(stage),
		.loadPixel(loadPixel),
		.commitPixel(commitPixel),
		.runInc(runInc),
		.runClear(runClear),
		.byteSource(byteSource),
		.emit(emit),
		.busy(busy),
		.done(done)
	);

	runCounter runs (
		.clk(clk),
		.reset(reset),
		.runInc(runInc),
		.runClear(runClear),
		.runCount(runCount),
		.runFull(runFull)
	);

	pixelHistory history (
		.clk(clk),
		.reset(reset),
		.pixelData(pixelData),
		.loadPixel(loadPixel),
		.commitPixel(commitPixel),
		.stage(stage)
	);

	chunkFormatter formatter (
		.stage(stage),
		.runCount(runCount),
		.byteSource(byteSource),
		.byteOut(byteOut)
	);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			byteValid <= 1'b0;
		end else begin
			byteValid <= emit;
		end
	end

	always_ff @(posedge clk) begin
		byteData <= byteOut;
	end
endmodule

//--- tests/qoiRefModel.svh
// Software QOI encoder used to predict the DUT byte stream
// Assumes a cleared colour table as after reset; no QOI file header
`include "qoi_settings.svh"

task automatic encodeImage(input logic [31:0] pixels[$], output logic [7:0] stream[$]);
	logic [31:0] seen [`QOI_TABLE_SIZE];
	logic [31:0] prev;
	logic [31:0] px;
	int run;
	int h;
	int r, g, b, a;
	int dr, dg, db, drg, dbg;
	stream = {};
	prev = `QOI_START_PIXEL;
	run = 0;
	for (int i = 0; i < `QOI_TABLE_SIZE; i++) begin
		seen[i] = 32'h0;
	end
	foreach (pixels[n]) begin
		px = pixels[n];
		if (px == prev) begin
			run++;
			if (run == `QOI_MAX_RUN || n == pixels.size() - 1) begin
				stream.push_back({`QOI_TAG_RUN, 6'(run - 1)});
				run = 0;
			end
		end else begin
			// Pending run first
			if (run > 0) begin
				stream.push_back({`QOI_TAG_RUN, 6'(run - 1)});
				run = 0;
			end
			r = int'(px[31:24]);
			g = int'(px[23:16]);
			b = int'(px[15:8]);
			a = int'(px[7:0]);
			h = (r * `QOI_HASH_R + g * `QOI_HASH_G + b * `QOI_HASH_B + a * `QOI_HASH_A)
				% `QOI_TABLE_SIZE;
			dr = r - int'(prev[31:24]);
			dg = g - int'(prev[23:16]);
			db = b - int'(prev[15:8]);
			drg = dr - dg;
			dbg = db - dg;
			if (seen[6'(h)] == px) begin
				stream.push_back({`QOI_TAG_INDEX, 6'(h)});
			end else begin
				seen[6'(h)] = px;
				if (a != int'(prev[7:0])) begin
					stream.push_back(`QOI_TAG_RGBA);
					stream.push_back(8'(r));
					stream.push_back(8'(g));
					stream.push_back(8'(b));
					stream.push_back(8'(a));
				end else if (dr >= -2 && dr < 2 && dg >= -2 && dg < 2 && db >= -2 && db < 2) begin
					stream.push_back({`QOI_TAG_DIFF, 2'(dr + `QOI_DIFF_BIAS),
						2'(dg + `QOI_DIFF_BIAS), 2'(db + `QOI_DIFF_BIAS)});
				end else if (dg >= -32 && dg < 32 && drg >= -8 && drg < 8
					&& dbg >= -8 && dbg < 8) begin
					stream.push_back({`QOI_TAG_LUMA, 6'(dg + `QOI_LUMA_G_BIAS)});
					stream.push_back({4'(drg + `QOI_LUMA_RB_BIAS), 4'(dbg + `QOI_LUMA_RB_BIAS)});
				end else begin
					stream.push_back(`QOI_TAG_RGB);
					stream.push_back(8'(r));
					stream.push_back(8'(g));
					stream.push_back(8'(b));
				end
			end
		end
		prev = px;
	end
	// End marker
	for (int i = 0; i < `QOI_END_BYTES - 1; i++) begin
		stream.push_back(8'h00);
	end
	stream.push_back(8'h01);
endtask

//--- tests/qoiEncoderTb.sv
// Testbench for the QOI encoder core
// Every table row is one image and the DUT is reset before each row
`timescale 1ns/1ns
`include "qoi_settings.svh"

module qoiEncoderTb;
	logic clk;
	logic reset;
	logic pixelValid;
	logic [31:0] pixelData;
	logic lastPixel;
	logic busy;
	logic byteValid;
	logic [7:0] byteData;
	logic done;

	// Image table built from segments
	// Modes are fixed (0), random (1) and near the previous pixel (2)
	logic [31:0] segPixel [$];
	int segCount [$];
	int segMode [$];
	bit segRowEnd [$];

	logic [7:0] gotBytes [$];
	bit collecting;
	bit tableReady;
	int errorCount;
	int seed;
	longint watchdogNs;

	`include "qoiRefModel.svh"

	qoiEncoder UUT (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.pixelData(pixelData),
		.lastPixel(lastPixel),
		.busy(busy),
		.byteValid(byteValid),
		.byteData(byteData),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Bytes are stable at the falling edge
	always @(negedge clk) begin
		if (collecting && byteValid) begin
			gotBytes.push_back(byteData);
		end
	end

	task automatic addSegment(input logic [31:0] px, input int count, input int mode,
		input bit rowEnd);
		segPixel.push_back(px);
		segCount.push_back(count);
		segMode.push_back(mode);
		segRowEnd.push_back(rowEnd);
	endtask

	task automatic buildTable();
		// Run at the start, then a mixed pixel
		addSegment(32'h000000FF, 3, 0, 0);
		addSegment(32'h11223344, 1, 0, 1);
		// Runs of 62 and 8, the second flushed by the last pixel
		addSegment(32'h000000FF, 70, 0, 1);
		// Hash slots 32 and 2, revisited for INDEX
		addSegment(32'h10203040, 1, 0, 0);
		addSegment(32'h11223380, 1, 0, 0);
		addSegment(32'h10203040, 1, 0, 0);
		addSegment(32'h11223380, 2, 0, 1);
		// RGB, DIFF, LUMA, LUMA at green -32, RGB at green +32, negative DIFF
		addSegment(32'h404040FF, 1, 0, 0);
		addSegment(32'h414140FF, 1, 0, 0);
		addSegment(32'h4A4D4BFF, 1, 0, 0);
		addSegment(32'h2A2D2BFF, 1, 0, 0);
		addSegment(32'h2A4D2BFF, 1, 0, 0);
		addSegment(32'h294C2AFF, 1, 0, 1);
		addSegment(32'h102030FF, 1, 0, 0);
		addSegment(32'h10203080, 1, 0, 0);
		addSegment(32'h9F8F7F80, 1, 0, 1);
		addSegment(32'h0, 20, 1, 1);
		addSegment(32'h0, 40, 2, 1);
		addSegment(32'h000000FF, 1, 0, 1);
		addSegment(32'h80808080, 1, 0, 0);
		addSegment(32'h0, 30, 2, 1);
	endtask

	function automatic logic [31:0] nearPixel(input logic [31:0] prev);
		logic [31:0] next;
		int delta;
		next = prev;
		// Keep one pixel in four unchanged so runs show up
		if ($random(seed) % 4 != 0) begin
			for (int c = 1; c < 4; c++) begin
				delta = $random(seed) % 21;
				next[c*8 +: 8] = 8'(int'(prev[c*8 +: 8]) + delta);
			end
		end
		return next;
	endfunction

	task automatic resetDut();
		reset = 1'b1;
		pixelValid = 1'b0;
		lastPixel = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;
		if (busy !== 1'b0) begin
			$display("FAILED time %0t: busy is %b after reset, expected 0", $time, busy);
			errorCount++;
		end
		if (byteValid !== 1'b0) begin
			$display("FAILED time %0t: byteValid is %b after reset, expected 0", $time,
				byteValid);
			errorCount++;
		end
		if (done !== 1'b0) begin
			$display("FAILED time %0t: done is %b after reset, expected 0", $time, done);
			errorCount++;
		end
	endtask

	task automatic sendPixel(input logic [31:0] px, input bit last);
		int waited;
		waited = 0;
		while (busy && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (busy) begin
			$display("Time %0t: DUT stayed busy and could not take pixel %08h", $time, px);
			errorCount++;
		end
		pixelValid = 1'b1;
		pixelData = px;
		lastPixel = last;
		@(posedge clk);
		#2;
		pixelValid = 1'b0;
		lastPixel = 1'b0;
	endtask

	task automatic runImage(input int row, input logic [31:0] pixels[$]);
		logic [7:0] expBytes [$];
		int waited;
		resetDut();
		gotBytes = {};
		collecting = 1'b1;
		foreach (pixels[n]) begin
			sendPixel(pixels[n], n == pixels.size() - 1);
		end
		waited = 0;
		while (!done && waited < 40) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!done) begin
			$display("Time %0t: done did not rise at the end of row %0d", $time, row);
			errorCount++;
		end else begin
			repeat (4) begin
				@(posedge clk);
				#2;
				if (done !== 1'b1) begin
					$display("FAILED time %0t: done is %b after the end of row %0d, expected 1",
						$time, done, row);
					errorCount++;
				end
				if (busy !== 1'b1) begin
					$display("FAILED time %0t: busy is %b after the end of row %0d, expected 1",
						$time, busy, row);
					errorCount++;
				end
			end
		end
		collecting = 1'b0;
		encodeImage(pixels, expBytes);
		if (gotBytes.size() != expBytes.size()) begin
			$display("Time %0t: row %0d gave %0d bytes but %0d were expected", $time, row,
				gotBytes.size(), expBytes.size());
			errorCount++;
		end
		for (int i = 0; i < expBytes.size() && i < gotBytes.size(); i++) begin
			if (gotBytes[i] !== expBytes[i]) begin
				$display("FAILED time %0t: byteData byte %0d of row %0d is %02h, expected %02h",
					$time, i, row, gotBytes[i], expBytes[i]);
				errorCount++;
			end
		end
	endtask

	initial begin
		logic [31:0] rowPixels [$];
		logic [31:0] px;
		int row;
		int totalPixels;
		int rowTotal;
		reset = 1'b1;
		pixelValid = 1'b0;
		pixelData = 32'h0;
		lastPixel = 1'b0;
		collecting = 1'b0;
		errorCount = 0;
		seed = 32'h2d4b6cd0;
		buildTable();
		totalPixels = 0;
		rowTotal = 0;
		foreach (segCount[s]) begin
			totalPixels += segCount[s];
			if (segRowEnd[s]) begin
				rowTotal++;
			end
		end
		// Eight cycles per pixel and 20 per row
		watchdogNs = (longint'(totalPixels) * 8 + longint'(rowTotal) * 20) * 40;
		tableReady = 1'b1;
		row = 0;
		px = `QOI_START_PIXEL;
		foreach (segCount[s]) begin
			for (int k = 0; k < segCount[s]; k++) begin
				case (segMode[s])
					1: px = $random(seed);
					2: px = nearPixel(px);
					default: px = segPixel[s];
				endcase
				rowPixels.push_back(px);
			end
			if (segRowEnd[s]) begin
				runImage(row, rowPixels);
				rowPixels = {};
				px = `QOI_START_PIXEL;
				row++;
			end
		end
		$display("Rows: %0d, pixels: %0d, errors: %0d", rowTotal, totalPixels, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		wait (tableReady);
		#(watchdogNs);
		$display("Watchdog expired after %0d ns and the run was stopped", watchdogNs);
		$display("Test FAILED");
		$finish;
	end
endmodule

//--- all.f
+incdir+verilog
+incdir+tests
verilog/qoiPkg.sv
verilog/qoiStageIf.sv
verilog/runCounter.sv
verilog/pixelHistory.sv
verilog/chunkFormatter.sv
verilog/qoiControl.sv
verilog/qoiEncoder.sv
tests/qoiEncoderTb.sv

//--- run.sh
#!/bin/sh
# Build the QOI encoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module qoiEncoderTb -o simQoi

./obj_dir/simQoi > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
